/* src/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // ================================================
    // Widths and word types
    // ================================================
    localparam int wordWidth    = 16;  // Data and instruction word
    localparam int addrWidth    = 15;  // Address as seen outside the core
    localparam int memAddrWidth = 10;  // Index into the local data memory
    localparam int memDepth     = 1 << memAddrWidth;

    typedef logic [wordWidth-1:0]    tWord;
    typedef logic [addrWidth-1:0]    tAddr;     // Instruction or data address
    typedef logic [memAddrWidth-1:0] tMemAddr;  // Low bits of A
    typedef logic [5:0]              tAluFn;    // zx nx zy ny f no

    // Bit 2 jumps on negative, bit 1 on zero, bit 0 on positive
    typedef enum logic [2:0] {
        noJmp = 3'b000,
        jgt   = 3'b001,
        jeq   = 3'b010,
        jge   = 3'b011,
        jlt   = 3'b100,
        jne   = 3'b101,
        jle   = 3'b110,
        jmp   = 3'b111
    } tJumpCond;

    // ================================================
    // Instruction field positions
    // ================================================
    localparam int typeBit  = 15;  // Clear for an A-instruction
    localparam int aBit     = 12;  // Set takes M as the second operand
    localparam int compHi   = 11;
    localparam int compLo   = 6;
    localparam int destABit = 5;
    localparam int destDBit = 4;
    localparam int destMBit = 3;
    localparam int jumpHi   = 2;
    localparam int jumpLo   = 0;

    // Hack computation codes, written for the A operand
    // Same codes with the a-bit set use M instead
    localparam tAluFn aluZero     = 6'b101010;
    localparam tAluFn aluOne      = 6'b111111;
    localparam tAluFn aluMinusOne = 6'b111010;
    localparam tAluFn aluD        = 6'b001100;
    localparam tAluFn aluA        = 6'b110000;
    localparam tAluFn aluNotD     = 6'b001101;
    localparam tAluFn aluNotA     = 6'b110001;
    localparam tAluFn aluNegD     = 6'b001111;
    localparam tAluFn aluNegA     = 6'b110011;
    localparam tAluFn aluDPlus1   = 6'b011111;
    localparam tAluFn aluAPlus1   = 6'b110111;
    localparam tAluFn aluDMinus1  = 6'b001110;
    localparam tAluFn aluAMinus1  = 6'b110010;
    localparam tAluFn aluDPlusA   = 6'b000010;
    localparam tAluFn aluDMinusA  = 6'b010011;
    localparam tAluFn aluAMinusD  = 6'b000111;
    localparam tAluFn aluDAndA    = 6'b000000;
    localparam tAluFn aluDOrA     = 6'b010101;

endpackage

`default_nettype wire

/* src/cpuIf.sv */
`default_nettype none

// Decode to execute, registered stage 102 control bundle
interface decIf import cpuPkg::*; ();
    logic     valid;       // Low for squashed or empty slots
    logic     isAType;
    tWord     immediate;   // Constant of an A-instruction
    tAluFn    aluFn;
    logic     selM;        // M instead of A as ALU operand
    logic     writeA;
    logic     writeD;
    logic     writeM;
    tJumpCond jumpCond;
    logic     jumpTaken;   // Back from execute
    tAddr     jumpTarget;

    modport decode (output valid, isAType, immediate, aluFn, selM,
                    output writeA, writeD, writeM, jumpCond,
                    input  jumpTaken, jumpTarget);
    modport execute (input  valid, isAType, immediate, aluFn, selM,
                     input  writeA, writeD, writeM, jumpCond,
                     output jumpTaken, jumpTarget);
endinterface

// Execute to result, memory read request and write request
interface resIf import cpuPkg::*; ();
    tMemAddr readAddr;  // Forwarded A for the next instruction
    tWord    aluData;
    tAddr    wrAddr;
    logic    wrEn;      // One per memory write
    tWord    memData;   // M with recent writes already merged

    modport execute (output readAddr, aluData, wrAddr, wrEn, input memData);
    modport result (input readAddr, aluData, wrAddr, wrEn, output memData);
endinterface

`default_nettype wire

/* src/decodeStage.sv */
`default_nettype none

module decodeStage import cpuPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  tWord inst,      // Word fetched at the previous instAddr
    output tAddr instAddr,
    decIf.decode dec
);

    tAddr       pc;          // Address currently being fetched
    tAddr       nextPc;
    logic       running;     // Low in the first cycle after reset
    logic [1:0] squashCnt;   // Decode slots still to kill after a jump or reset
    logic [1:0] killCnt;
    logic       squash;
    logic       isC;

    assign instAddr = pc;
    assign isC      = inst[typeBit];

    // A taken jump kills the slot in decode now and the one after it
    assign killCnt = dec.jumpTaken ? 2'd2 : squashCnt;
    assign squash  = (killCnt != 2'd0);

    // ================================================
    // Program counter
    // ================================================
    always_comb begin
        if (dec.jumpTaken) begin
            nextPc = dec.jumpTarget;
        end else if (running) begin
            nextPc = pc + tAddr'(1);
        end else begin
            nextPc = pc;     // Hold 0 until word 0 has been fetched
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc        <= '0;
            running   <= 1'b0;
            squashCnt <= 2'd2;   // Word 0 reaches decode in the third cycle
        end else begin
            pc        <= nextPc;
            running   <= 1'b1;
            squashCnt <= (killCnt != 2'd0) ? killCnt - 2'd1 : 2'd0;
        end
    end

    // ================================================
    // Field decode into stage 102
    // ================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dec.valid    <= 1'b0;
            dec.writeA   <= 1'b0;
            dec.writeD   <= 1'b0;
            dec.writeM   <= 1'b0;
            dec.jumpCond <= noJmp;
        end else begin
            dec.valid    <= !squash;
            dec.writeA   <= isC && inst[destABit];   // Destinations only for C
            dec.writeD   <= isC && inst[destDBit];
            dec.writeM   <= isC && inst[destMBit];
            dec.jumpCond <= isC ? tJumpCond'(inst[jumpHi:jumpLo]) : noJmp;
        end
    end

    // Payload fields, qualified downstream by valid
    always_ff @(posedge clk) begin
        dec.isAType   <= !isC;
        dec.immediate <= {1'b0, inst[addrWidth-1:0]};   // 15 bit constant
        dec.aluFn     <= inst[compHi:compLo];
        dec.selM      <= inst[aBit];
    end

endmodule

`default_nettype wire

/* src/executeStage.sv */
`default_nettype none

module executeStage import cpuPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    decIf.execute dec,
    resIf.execute res
);

    tWord aReg;
    tWord dReg;
    tWord nextA;
    tWord nextD;
    tWord aluY;        // A or M
    tWord xIn;         // After zx nx
    tWord yIn;         // After zy ny
    tWord fOut;
    tWord aluOut;
    logic doA;
    logic doD;
    logic neg;
    logic zero;
    logic pos;
    logic condMet;

    // Zero then invert one ALU input
    function automatic tWord presetIn(input tWord v, input logic z, input logic n);
        tWord t;
        t = z ? '0 : v;
        return n ? ~t : t;
    endfunction

    // ================================================
    // Hack ALU
    // ================================================
    // M comes from result, already merged with writes of the last two instructions
    assign aluY = dec.selM ? res.memData : aReg;

    assign xIn  = presetIn(dReg, dec.aluFn[5], dec.aluFn[4]);
    assign yIn  = presetIn(aluY, dec.aluFn[3], dec.aluFn[2]);
    assign fOut = dec.aluFn[1] ? xIn + yIn : xIn & yIn;   // f selects add or and
    assign aluOut = dec.aluFn[0] ? ~fOut : fOut;          // no

    // Flags of the result
    assign neg  = aluOut[wordWidth-1];
    assign zero = (aluOut == '0);
    assign pos  = !neg && !zero;

    // ================================================
    // Jump resolution
    // ================================================
    assign condMet = (neg  && dec.jumpCond[2])
                  || (zero && dec.jumpCond[1])
                  || (pos  && dec.jumpCond[0]);

    assign dec.jumpTaken  = dec.valid && !dec.isAType && condMet;
    assign dec.jumpTarget = aReg[addrWidth-1:0];   // A before this instruction writes it

    // ================================================
    // A and D registers
    // ================================================
    assign doA = dec.valid && (dec.isAType || dec.writeA);
    assign doD = dec.valid && dec.writeD;

    always_comb begin
        nextA = aReg;
        if (doA) begin
            nextA = dec.isAType ? dec.immediate : aluOut;
        end
    end

    // Written at the end of the cycle, so the next instruction reads it with no stall
    assign nextD = doD ? aluOut : dReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aReg <= '0;
            dReg <= '0;
        end else begin
            aReg <= nextA;
            dReg <= nextD;
        end
    end

    // ================================================
    // Memory requests
    // ================================================
    // Read for the instruction now in decode uses A as this one leaves it
    assign res.readAddr = nextA[memAddrWidth-1:0];

    assign res.aluData = aluOut;
    assign res.wrAddr  = aReg[addrWidth-1:0];     // M is addressed by the old A
    assign res.wrEn    = dec.valid && dec.writeM;  // Squashed slots never write

endmodule

`default_nettype wire

/* src/resultStage.sv */
`default_nettype none

module resultStage import cpuPkg::*; (
    input  logic clk,
    input  logic arstN,
    resIf.result res,
    output tWord outM,
    output logic writeM,
    output tAddr dataAddr
);

    tWord    mem [memDepth];   // Local data memory
    tWord    rdData;           // Raw registered read
    tMemAddr rdAddr;           // Address of that read

    // Write pipeline, 103 is the cycle after execute
    logic    wrEn103;
    tAddr    wrAddr103;
    tWord    wrData103;
    logic    wrEn104;
    tMemAddr wrAddr104;
    tWord    wrData104;
    logic    hit103;
    logic    hit104;

    // ================================================
    // Write request pipeline
    // ================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrEn103 <= 1'b0;
            wrEn104 <= 1'b0;
        end else begin
            wrEn103 <= res.wrEn;
            wrEn104 <= wrEn103;
        end
    end

    always_ff @(posedge clk) begin
        wrAddr103 <= res.wrAddr;
        wrData103 <= res.aluData;
        wrAddr104 <= wrAddr103[memAddrWidth-1:0];
        wrData104 <= wrData103;
    end

    // ================================================
    // Memory array
    // ================================================
    always_ff @(posedge clk) begin
        if (wrEn103) begin
            mem[wrAddr103[memAddrWidth-1:0]] <= wrData103;   // Write at end of 103
        end
        rdData <= mem[res.readAddr];   // Old data on a same cycle write
        rdAddr <= res.readAddr;
    end

    // Writes of the previous two instructions are not yet in rdData
    assign hit103 = wrEn103 && (wrAddr103[memAddrWidth-1:0] == rdAddr);
    assign hit104 = wrEn104 && (wrAddr104 == rdAddr);

    // Newest write wins
    always_comb begin
        if (hit103) begin
            res.memData = wrData103;
        end else if (hit104) begin
            res.memData = wrData104;
        end else begin
            res.memData = rdData;
        end
    end

    // ================================================
    // Mirror to the outside
    // ================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            writeM <= 1'b0;
        end else begin
            writeM <= wrEn103;   // Two cycles after execute
        end
    end

    always_ff @(posedge clk) begin
        outM     <= wrData103;
        dataAddr <= wrAddr103;
    end

endmodule

`default_nettype wire

/* src/cpu.sv */
`default_nettype none

// Three stage Hack core
// Data memory lives inside, every write is mirrored out two cycles after execute
module cpu import cpuPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  tWord inst,       // From synchronous instruction memory
    output tAddr instAddr,
    output tWord outM,       // Mirrored write data
    output logic writeM,     // Single cycle strobe per write
    output tAddr dataAddr
);

    // ================================================
    // Stage buses
    // ================================================
    decIf decBus ();   // 101 -> 102 control, jump back to fetch
    resIf resBus ();   // 102 -> 103 requests, M back to execute

    // ================================================
    // Stages
    // ================================================

    // Fetch and decode, cycle 101
    decodeStage decode_i (
        .clk      (clk),
        .arstN    (arstN),
        .inst     (inst),
        .instAddr (instAddr),
        .dec      (decBus)
    );

    // ALU, A and D, jump, cycle 102
    executeStage execute_i (
        .clk   (clk),
        .arstN (arstN),
        .dec   (decBus),
        .res   (resBus)
    );

    // Memory, forwarding and mirror, cycles 103 and 104
    resultStage result_i (
        .clk      (clk),
        .arstN    (arstN),
        .res      (resBus),
        .outM     (outM),
        .writeM   (writeM),
        .dataAddr (dataAddr)
    );

endmodule

`default_nettype wire

/* verification/cpuChecker.sv */
`default_nettype none

module cpuChecker import cpuPkg::*; (
    input logic clk,
    input logic arstN,
    input logic writeM,
    input tWord outM,
    input tAddr dataAddr
);

    tAddr  expAddr [$];
    tWord  expData [$];
    tWord  modelMem [memDepth];   // Persists across programs like the DUT memory
    string testName;
    int    valueErrs = 0;
    int    otherErrs = 0;

    // Hack computation table
    function automatic tWord hackAlu(input tAluFn fn, input tWord d, input tWord y);
        case (fn)
            aluZero:     return 16'd0;
            aluOne:      return 16'd1;
            aluMinusOne: return 16'hffff;
            aluD:        return d;
            aluA:        return y;
            aluNotD:     return ~d;
            aluNotA:     return ~y;
            aluNegD:     return -d;
            aluNegA:     return -y;
            aluDPlus1:   return d + 16'd1;
            aluAPlus1:   return y + 16'd1;
            aluDMinus1:  return d - 16'd1;
            aluAMinus1:  return y - 16'd1;
            aluDPlusA:   return d + y;
            aluDMinusA:  return d - y;
            aluAMinusD:  return y - d;
            aluDAndA:    return d & y;
            aluDOrA:     return d | y;
            default:     return 16'd0;
        endcase
    endfunction

    // ================================================
    // Sequential model, fills the expected write queue
    // ================================================
    task automatic predict(input string name, input tWord prog [32], input int len);
        tWord a;
        tWord d;
        tWord y;
        tWord r;
        tWord w;
        tWord oldA;
        int   pc;
        logic halted;
        logic met;
        testName = name;
        a = '0;
        d = '0;
        pc = 0;
        halted = 1'b0;
        for (int step = 0; step < 500 && !halted; step++) begin
            w = (pc < len) ? prog[pc] : 16'd0;
            if (!w[15]) begin
                a = {1'b0, w[14:0]};
                pc++;
            end else begin
                oldA = a;
                y = w[12] ? modelMem[a[9:0]] : a;
                r = hackAlu(w[11:6], d, y);
                met = (w[2] && r[15]) || (w[1] && r == 0) || (w[0] && !r[15] && r != 0);
                if (w[3]) begin
                    expAddr.push_back(oldA[14:0]);
                    expData.push_back(r);
                    modelMem[oldA[9:0]] = r;
                end
                if (w[5]) a = r;
                if (w[4]) d = r;
                // Unconditional jump back onto itself ends the program
                if (w[2:0] == 3'b111 && (int'(oldA) == pc - 1 || int'(oldA) == pc)) halted = 1'b1;
                pc = met ? int'(oldA[14:0]) : pc + 1;
            end
        end
        if (!halted) begin
            $display("Model of %s never reached its final loop", name);
            otherErrs++;
        end
    endtask

    function automatic int pending();
        return expAddr.size();
    endfunction

    task automatic endProgram();
        while (expAddr.size() != 0) begin
            $display("%s: expected write of %h to %h never happened",
                     testName, expData[0], expAddr[0]);
            void'(expAddr.pop_front());
            void'(expData.pop_front());
            otherErrs++;
        end
    endtask

    // Compare every mirrored write in program order
    always @(posedge clk) begin
        if (arstN && writeM) begin
            if (expAddr.size() == 0) begin
                $display("%s: unexpected write of %h to %h", testName, outM, dataAddr);
                otherErrs++;
            end else begin
                if (expAddr[0] != dataAddr || expData[0] != outM) begin
                    $display("Fail %s: expected %h at %h, actual %h at %h",
                             testName, expData[0], expAddr[0], outM, dataAddr);
                    valueErrs++;
                end
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

/* verification/cpu_assert.sv */
`default_nettype none

module cpu_assert import cpuPkg::*; (
    input logic clk,
    input logic arstN,
    input logic writeM,
    input tAddr instAddr,
    input logic jumpTaken
);

    // Slots after a taken jump would reach the mirror three and four cycles later
    squashNoWrite: assert property (@(posedge clk) disable iff (!arstN)
        jumpTaken |-> ##3 !writeM ##1 !writeM)
        else $error("Write from an instruction squashed by a jump");

    noWriteInReset: assert property (@(posedge clk) !arstN |-> !writeM)
        else $error("writeM high during reset");

    // First fetch address held while word 0 arrives
    pcHoldAfterReset: assert property (@(posedge clk)
        $rose(arstN) |-> (instAddr == '0) ##1 (instAddr == '0))
        else $error("instAddr moved too early after reset");

endmodule

bind cpu cpu_assert assert_i (
    .clk       (clk),
    .arstN     (arstN),
    .writeM    (writeM),
    .instAddr  (instAddr),
    .jumpTaken (decBus.jumpTaken)
);

`default_nettype wire

/* verification/cpuTb.sv */
`default_nettype none

module cpuTb import cpuPkg::*;;

    localparam int numProgs = 6;
    localparam int progLen  = 32;
    localparam int period   = 20;

    logic  clk;
    logic  arstN;
    tWord  inst;
    tAddr  instAddr;
    tWord  outM;
    logic  writeM;
    tAddr  dataAddr;

    tWord  progTable [numProgs][progLen];  // Program words, built at start
    int    lens [numProgs];
    string names [numProgs];
    tWord  imem [progLen];                 // Program being served
    logic [31:0] lfsr;
    int    cur;
    int    totalInstr;
    int    waitCycles;                     // Cycles spent waiting on the current program
    logic  built;

    cpu dut_i (.clk(clk), .arstN(arstN), .inst(inst), .instAddr(instAddr),
               .outM(outM), .writeM(writeM), .dataAddr(dataAddr));

    cpuChecker check_i (.clk(clk), .arstN(arstN), .writeM(writeM), .outM(outM),
                        .dataAddr(dataAddr));

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Synchronous instruction memory
    always @(posedge clk) begin
        inst <= (instAddr < tAddr'(progLen)) ? imem[instAddr[4:0]] : '0;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic tWord randBits(input int n);
        tWord v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[wordWidth-2:0], fb};
        end
        return v;
    endfunction

    function automatic tWord aInst(input int v);
        return {1'b0, 15'(v)};
    endfunction

    // dest is {A, D, M}
    function automatic tWord cInst(input logic selM, input tAluFn fn, input logic [2:0] dest,
                                   input logic [2:0] jmpBits);
        return {3'b111, selM, fn, dest, jmpBits};
    endfunction

    task automatic emit(input int p, input tWord w);
        progTable[p][cur] = w;
        cur++;
    endtask

    // Two instruction loop that ends every program
    task automatic finishProg(input int p);
        emit(p, aInst(cur));
        emit(p, cInst(1'b0, aluZero, 3'b000, 3'b111));
        lens[p] = cur;
    endtask

    task automatic buildPrograms();
        tWord v;
        for (int p = 0; p < numProgs; p++) begin
            for (int i = 0; i < progLen; i++) progTable[p][i] = '0;
        end
        // ALU functions on D and M
        names[0] = "aluOps";
        cur = 0;
        emit(0, aInst(randBits(15)));
        emit(0, cInst(0, aluA, 3'b010, 0));
        emit(0, aInst(5));
        emit(0, cInst(0, aluD, 3'b001, 0));
        emit(0, aInst(randBits(15)));
        emit(0, cInst(0, aluDPlusA, 3'b010, 0));
        emit(0, aInst(6));
        emit(0, cInst(0, aluD, 3'b001, 0));
        emit(0, aInst(5));
        emit(0, cInst(1, aluDMinusA, 3'b010, 0));
        emit(0, aInst(7));
        emit(0, cInst(0, aluD, 3'b001, 0));
        emit(0, cInst(1, aluNotA, 3'b001, 0));
        emit(0, cInst(1, aluAPlus1, 3'b001, 0));
        emit(0, cInst(1, aluDOrA, 3'b010, 0));
        emit(0, aInst(8));
        emit(0, cInst(0, aluNegD, 3'b001, 0));
        emit(0, cInst(1, aluDAndA, 3'b001, 0));
        emit(0, cInst(0, aluNotD, 3'b010, 0));
        emit(0, cInst(0, aluDMinus1, 3'b001, 0));
        emit(0, cInst(1, aluAMinusD, 3'b010, 0));
        emit(0, aInst(9));
        emit(0, cInst(0, aluD, 3'b001, 0));
        emit(0, cInst(0, aluOne, 3'b001, 0));
        emit(0, cInst(1, aluNegA, 3'b001, 0));
        emit(0, cInst(0, aluMinusOne, 3'b010, 0));
        finishProg(0);
        // Back to back M writes and reads
        names[1] = "rawM";
        cur = 0;
        emit(1, cInst(0, aluDPlus1, 3'b001, 0));   // Word 0 writes, must run once
        emit(1, aInst(10));
        emit(1, cInst(0, aluOne, 3'b001, 0));
        emit(1, cInst(1, aluAPlus1, 3'b001, 0));
        emit(1, cInst(1, aluAPlus1, 3'b001, 0));
        emit(1, cInst(1, aluA, 3'b010, 0));
        emit(1, aInst(11));
        emit(1, cInst(0, aluD, 3'b001, 0));
        emit(1, cInst(1, aluAMinus1, 3'b001, 0));
        emit(1, cInst(1, aluDPlusA, 3'b010, 0));
        emit(1, aInst(10));
        emit(1, cInst(0, aluD, 3'b001, 0));
        emit(1, cInst(0, aluDPlus1, 3'b010, 0));   // Next read sees a write two back
        emit(1, cInst(1, aluDMinusA, 3'b011, 0));  // MD
        finishProg(1);
        // Every jump condition against a positive, zero and negative D
        for (int k = 0; k < 3; k++) begin
            names[2 + k] = (k == 0) ? "jumpPos" : (k == 1) ? "jumpZero" : "jumpNeg";
            cur = 0;
            v = randBits(14) | 16'd1;
            emit(2 + k, aInst(v));
            emit(2 + k, cInst(0, (k == 0) ? aluA : (k == 1) ? aluZero : aluNegA, 3'b010, 0));
            for (int c = 1; c < 8; c++) begin
                emit(2 + k, aInst(cur + 4));
                emit(2 + k, cInst(0, aluD, 3'b000, 3'(c)));
                emit(2 + k, aInst(100 + c));        // Marker, skipped on a taken jump
                emit(2 + k, cInst(0, aluD, 3'b001, 0));
            end
            finishProg(2 + k);
        end
        // A and D written then used at once
        names[5] = "adHazard";
        cur = 0;
        emit(5, aInst(randBits(15)));
        emit(5, cInst(0, aluA, 3'b010, 0));
        emit(5, cInst(0, aluDPlus1, 3'b110, 0));   // AD
        emit(5, cInst(0, aluDPlusA, 3'b010, 0));
        emit(5, aInst(13));
        emit(5, cInst(0, aluD, 3'b001, 0));
        emit(5, aInst(randBits(15)));
        emit(5, cInst(0, aluAPlus1, 3'b100, 0));
        emit(5, cInst(0, aluA, 3'b010, 0));
        emit(5, aInst(14));
        emit(5, cInst(0, aluD, 3'b001, 0));
        emit(5, aInst(15));
        emit(5, cInst(0, aluDPlus1, 3'b101, 0));  // AM
        emit(5, cInst(0, aluA, 3'b010, 0));
        emit(5, aInst(16));
        emit(5, cInst(0, aluD, 3'b001, 0));
        finishProg(5);
        totalInstr = 0;
        for (int p = 0; p < numProgs; p++) totalInstr += lens[p];
    endtask

    // ================================================
    // Program loop
    // ================================================
    initial begin
        arstN = 1'b0;
        inst  = '0;
        built = 1'b0;
        lfsr  = 32'h994efa26;
        for (int i = 0; i < progLen; i++) imem[i] = '0;
        buildPrograms();
        built = 1'b1;
        for (int p = 0; p < numProgs; p++) begin
            @(posedge clk);
            arstN <= 1'b0;
            for (int i = 0; i < progLen; i++) imem[i] = progTable[p][i];
            check_i.predict(names[p], imem, lens[p]);
            repeat (10) @(posedge clk);
            arstN <= 1'b1;
            // Missing writes are left in the queue and reported below
            waitCycles = 0;
            while (check_i.pending() != 0 && waitCycles < 40 * lens[p]) begin
                @(posedge clk);
                waitCycles++;
            end
            repeat (20) @(posedge clk);                      // Room for extra writes
            check_i.endProgram();
        end
        $display("Errors: %0d wrong value, %0d other", check_i.valueErrs, check_i.otherErrs);
        if (check_i.valueErrs + check_i.otherErrs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog, 40 cycles per table instruction per program
    initial begin
        wait (built);
        #(40 * totalInstr * numProgs * period);
        $display("Timeout: programs did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* cpu.f */
src/cpuPkg.sv
src/cpuIf.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/cpu.sv
verification/cpuChecker.sv
verification/cpu_assert.sv
verification/cpuTb.sv

/* Makefile */
TOP = cpuTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f cpu.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
